//--- testbench/movCore_stim.txt
# kind offset data err: W writes data, R reads and expects data, E writes an opcode and waits
# err is 1 where the access must end with pSlvErr
R 04 00 0
W 20 11 0
W 24 22 0
W 28 33 0
W 2c 44 0
W 30 01 0
W 34 80 0
W 3c 55 0
R 20 11 0
R 24 22 0
R 28 33 0
R 2c 44 0
R 30 01 0
R 34 80 0
R 3c 55 0
E 00 78 0
R 3c 11 0
R 20 11 0
R 28 33 0
E 00 7f 0
R 3c 11 0
E 00 71 0
R 38 22 0
W 38 9a 0
E 00 5e 0
R 2c 9a 0
E 00 76 0
R 04 02 0
R 20 11 0
R 38 9a 0
E 00 80 0
R 04 04 0
R 3c 11 0
W 00 41 0
E 00 50 0
R 20 22 0
R 28 22 0
R 04 00 0
R 10 00 1
W 04 01 1
R 40 00 1

//--- vlog.f
+incdir+include
rtl/movGroup_pkg.sv
rtl/movDecoder.sv
rtl/moveSequencer.sv
rtl/regFile.sv
rtl/scratchMemory.sv
rtl/apbHostPort.sv
rtl/movCore.sv
testbench/movChecker.sv
testbench/movCore_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module movCore_tb

output=$(./obj_dir/VmovCore_tb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
else
    exit 1
fi

//--- testbench/movCore_tb.sv
/* Move-group unit testbench */
`timescale 1ns/100ps
`default_nettype none

`include "movGroup_consts.svh"

module movCore_tb;

    logic clk;
    logic rst;
    logic pSel;
    logic pEnable;
    logic pWrite;
    logic [7:0] pAddr;
    logic [7:0] pWdata;
    logic [7:0] pRdata;
    logic pReady;
    logic pSlvErr;
    logic expCheck;
    logic [7:0] expData;
    logic expErr;
    logic [7:0] lastRdata;
    int mismatchCount;
    int busErrCount;
    int timeoutCount;
    int setupErrors;

    movCore uut (
        .clk(clk),
        .rst(rst),
        .pSel(pSel),
        .pEnable(pEnable),
        .pWrite(pWrite),
        .pAddr(pAddr),
        .pWdata(pWdata),
        .pRdata(pRdata),
        .pReady(pReady),
        .pSlvErr(pSlvErr)
    );

    movChecker scoreboard (
        .clk(clk),
        .rst(rst),
        .pSel(pSel),
        .pEnable(pEnable),
        .pWrite(pWrite),
        .pAddr(pAddr),
        .pRdata(pRdata),
        .pReady(pReady),
        .pSlvErr(pSlvErr),
        .expCheck(expCheck),
        .expData(expData),
        .expErr(expErr),
        .mismatchCount(mismatchCount),
        .busErrCount(busErrCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // drives one APB transfer whose setup and access phases start on falling edges
    task automatic apbTransfer(input logic write, input logic [7:0] addr, input logic [7:0] data);
        int waitCycles;
        waitCycles = 0;
        @(negedge clk);
        pSel = 1'b1;
        pEnable = 1'b0;
        pWrite = write;
        pAddr = addr;
        pWdata = data;
        @(negedge clk);
        pEnable = 1'b1;
        @(posedge clk);
        while (!pReady && waitCycles < 20) begin // an opcode write may be stalled here
            waitCycles++;
            @(posedge clk);
        end
        lastRdata = pRdata;
        if (!pReady) begin
            $display("Timeout at %0t: access to offset %h never saw pReady", $time, addr);
            timeoutCount++;
        end
        @(negedge clk);
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
    endtask

    task automatic waitIdle();
        int polls;
        polls = 0;
        lastRdata = 8'h01;
        expCheck = 1'b0;
        expErr = 1'b0;
        while (lastRdata[`MOV_ST_BUSY] && polls < 20 && timeoutCount == 0) begin
            apbTransfer(1'b0, `MOV_OFS_STATUS, 8'h00);
            polls++;
        end
        if (lastRdata[`MOV_ST_BUSY] && timeoutCount == 0) begin
            $display("Timeout at %0t: busy still set after 20 status reads", $time);
            timeoutCount++;
        end
    endtask

    task automatic runLine(input logic [7:0] kind, input logic [7:0] ofs,
                           input logic [7:0] dat, input logic err);
        expErr = err;
        case (kind)
            "W": begin
                expCheck = 1'b0;
                apbTransfer(1'b1, ofs, dat);
            end
            "R": begin
                expCheck = 1'b1;
                expData = dat;
                apbTransfer(1'b0, ofs, 8'h00);
            end
            "E": begin // opcode write, then poll until the move is done
                expCheck = 1'b0;
                apbTransfer(1'b1, ofs, dat);
                if (timeoutCount == 0) begin
                    waitIdle();
                end
            end
            default: begin
                $display("Unknown stimulus line kind %c", kind);
                setupErrors++;
            end
        endcase
    endtask

    initial begin
        int fd;
        int n;
        string line;
        logic [7:0] kind;
        logic [7:0] ofs;
        logic [7:0] dat;
        logic err;
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
        pAddr = 8'h00;
        pWdata = 8'h00;
        expCheck = 1'b0;
        expData = 8'h00;
        expErr = 1'b0;
        timeoutCount = 0;
        setupErrors = 0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd = $fopen("testbench/movCore_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            setupErrors++;
        end else begin
            while (!$feof(fd) && timeoutCount == 0) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h", kind, ofs, dat, err);
                    if (n == 4) begin
                        runLine(kind, ofs, dat, err);
                    end
                end
            end
            $fclose(fd);
        end
        repeat (2) @(negedge clk);
        $display("Errors: %0d mismatches, %0d bus errors, %0d timeouts, %0d setup errors",
                 mismatchCount, busErrCount, timeoutCount, setupErrors);
        if (mismatchCount == 0 && busErrCount == 0 && timeoutCount == 0 && setupErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/movChecker.sv
/* APB response checker */
`timescale 1ns/100ps
`default_nettype none

`include "movGroup_consts.svh"

module movChecker (
    input wire logic clk,
    input wire logic rst,
    input wire logic pSel,
    input wire logic pEnable,
    input wire logic pWrite,
    input wire logic [7:0] pAddr,
    input wire logic [7:0] pRdata,
    input wire logic pReady,
    input wire logic pSlvErr,
    input wire logic expCheck,
    input wire logic [7:0] expData,
    input wire logic expErr,
    output int mismatchCount,
    output int busErrCount
);

    logic done;
    logic opcodeWrite;

    assign done = pSel && pEnable && pReady; // access phase completes on this edge
    assign opcodeWrite = pWrite && (pAddr == `MOV_OFS_OPCODE); // the only access that may wait

    always @(posedge clk) begin
        if (rst) begin
            mismatchCount <= 0;
            busErrCount <= 0;
        end else if (done) begin
            if (pSlvErr !== expErr) begin
                $display("Mismatch at %0t: pSlvErr %b on %s of offset %h, expected %b",
                         $time, pSlvErr, pWrite ? "write" : "read", pAddr, expErr);
                busErrCount <= busErrCount + 1;
            end
            if (!pWrite && expCheck && pRdata !== expData) begin
                $display("Mismatch at %0t: read of offset %h returned %h, expected %h",
                         $time, pAddr, pRdata, expData);
                mismatchCount <= mismatchCount + 1;
            end
        end else if (pSel && pEnable && !opcodeWrite) begin
            $display("Mismatch at %0t: pReady low on %s of offset %h, expected high",
                     $time, pWrite ? "write" : "read", pAddr);
            busErrCount <= busErrCount + 1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/movCore.sv
/* Move-group execution unit */
`timescale 1ns/100ps
`default_nettype none

module movCore (
    input wire logic clk,
    input wire logic rst,
    input wire logic pSel,
    input wire logic pEnable,
    input wire logic pWrite,
    input wire logic [7:0] pAddr,
    input wire logic [7:0] pWdata,
    output logic [7:0] pRdata,
    output logic pReady,
    output logic pSlvErr
);
    import movGroup_pkg::*;

    logic opWrite;
    logic [7:0] opByte;
    logic hostRegWrite;
    regSel_e hostRegSel;
    logic [7:0] hostData;
    logic [7:0] hostReadData;
    logic opStall;
    logic busy;
    logic haltFlag;
    logic illegalFlag;
    xpt_e xpt;
    logic decEnable;
    logic [7:0] opcode;
    logic [7:0] readSel;
    logic [7:0] writeSel;
    logic memWrite;
    logic isHalt;
    logic isIllegal;
    logic [7:0] xferData;
    logic [7:0] memData;
    hlPair_u hl;
    logic memWe;
    logic [7:0] memWdata;

    apbHostPort hostPort (
        .clk(clk),
        .rst(rst),
        .pSel(pSel),
        .pEnable(pEnable),
        .pWrite(pWrite),
        .pAddr(pAddr),
        .pWdata(pWdata),
        .pRdata(pRdata),
        .pReady(pReady),
        .pSlvErr(pSlvErr),
        .busy(busy),
        .haltFlag(haltFlag),
        .illegalFlag(illegalFlag),
        .opStall(opStall),
        .hostReadData(hostReadData),
        .opWrite(opWrite),
        .opByte(opByte),
        .hostRegWrite(hostRegWrite),
        .hostRegSel(hostRegSel),
        .hostData(hostData)
    );

    moveSequencer sequencer (
        .clk(clk),
        .rst(rst),
        .opWrite(opWrite),
        .opByte(opByte),
        .isHalt(isHalt),
        .isIllegal(isIllegal),
        .xpt(xpt),
        .decEnable(decEnable),
        .opcode(opcode),
        .opStall(opStall),
        .busy(busy),
        .haltFlag(haltFlag),
        .illegalFlag(illegalFlag)
    );

    movDecoder decoder (
        .enable(decEnable),
        .xpt(xpt),
        .opcode(opcode),
        .readSel(readSel),
        .writeSel(writeSel),
        .selectAddrHL(),
        .memWrite(memWrite),
        .isHalt(isHalt),
        .isIllegal(isIllegal)
    );

    regFile regs (
        .clk(clk),
        .rst(rst),
        .hostRegWrite(hostRegWrite),
        .hostRegSel(hostRegSel),
        .hostData(hostData),
        .writeSel(writeSel),
        .readSel(readSel),
        .memData(memData),
        .xferData(xferData),
        .hostReadData(hostReadData),
        .hl(hl)
    );

    // the byte at HL is written by LD (HL),r or by a host preload of M
    assign memWe = memWrite || (hostRegWrite && (hostRegSel == REG_M));
    assign memWdata = memWrite ? xferData : hostData;

    scratchMemory scratch (
        .clk(clk),
        .addr(hl),
        .we(memWe),
        .wdata(memWdata),
        .rdata(memData)
    );

endmodule

`default_nettype wire

//--- rtl/apbHostPort.sv
/* APB host port */
`timescale 1ns/100ps
`default_nettype none

`include "movGroup_consts.svh"

module apbHostPort (
    input wire logic clk,
    input wire logic rst,
    input wire logic pSel,
    input wire logic pEnable,
    input wire logic pWrite,
    input wire logic [7:0] pAddr,
    input wire logic [7:0] pWdata,
    output logic [7:0] pRdata,
    output logic pReady,
    output logic pSlvErr,
    input wire logic busy,
    input wire logic haltFlag,
    input wire logic illegalFlag,
    input wire logic opStall,
    input wire logic [7:0] hostReadData,
    output logic opWrite,
    output logic [7:0] opByte,
    output logic hostRegWrite,
    output movGroup_pkg::regSel_e hostRegSel,
    output logic [7:0] hostData
);
    import movGroup_pkg::*;

    logic [7:0] regOfs;
    logic isOpcode;
    logic isStatus;
    logic isReg;
    logic done;
    logic [7:0] status;

    assign regOfs = pAddr - `MOV_OFS_REG;
    assign isOpcode = (pAddr == `MOV_OFS_OPCODE);
    assign isStatus = (pAddr == `MOV_OFS_STATUS);
    assign isReg = (regOfs[7:5] == 3'b000) && (regOfs[1:0] == 2'b00); // eight word slots

    assign pReady = !(pSel && pWrite && isOpcode && opStall); // only an opcode write waits
    assign done = pSel && pEnable && pReady;

    assign opWrite = done && pWrite && isOpcode;
    assign opByte = pWdata;
    assign hostRegWrite = done && pWrite && isReg;
    assign hostRegSel = regSel_e'(regOfs[4:2]);
    assign hostData = pWdata;

    // status is read only
    assign pSlvErr = done && (!(isOpcode || isStatus || isReg) || (pWrite && isStatus));

    always_comb begin
        status = '0;
        status[`MOV_ST_BUSY] = busy;
        status[`MOV_ST_HALT] = haltFlag;
        status[`MOV_ST_ILLEGAL] = illegalFlag;
        pRdata = '0;
        if (isStatus) begin
            pRdata = status;
        end else if (isReg) begin
            pRdata = hostReadData;
        end
    end

    // a stalled opcode write keeps its address and data until it completes
    assert property (@(posedge clk) disable iff (rst)
        (pSel && pEnable && !pReady) |=>
            (pSel && pEnable && $stable(pAddr) && $stable(pWrite) && $stable(pWdata)))
        else $error("apbHostPort: stalled transfer changed before completing");

endmodule

`default_nettype wire

//--- rtl/scratchMemory.sv
/* Scratch memory at HL */
`timescale 1ns/100ps
`default_nettype none

`include "movGroup_consts.svh"

module scratchMemory (
    input wire logic clk,
    input wire movGroup_pkg::hlPair_u addr,
    input wire logic we,
    input wire logic [7:0] wdata,
    output logic [7:0] rdata
);

    localparam int memDepth = 2 ** `MOV_MEM_AW;

    logic [7:0] mem [memDepth];
    logic [`MOV_MEM_AW-1:0] index;

    assign index = addr.addr[`MOV_MEM_AW-1:0]; // upper address bits fold onto the array

    // array comes up cleared
    initial begin
        for (int i = 0; i < memDepth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];

endmodule

`default_nettype wire

//--- rtl/regFile.sv
/* 8080 register file */
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input wire logic clk,
    input wire logic rst,
    input wire logic hostRegWrite,
    input wire movGroup_pkg::regSel_e hostRegSel,
    input wire logic [7:0] hostData,
    input wire logic [7:0] writeSel,
    input wire logic [7:0] readSel,
    input wire logic [7:0] memData,
    output logic [7:0] xferData,
    output logic [7:0] hostReadData,
    output movGroup_pkg::hlPair_u hl
);
    import movGroup_pkg::*;

    logic [7:0] regB;
    logic [7:0] regC;
    logic [7:0] regD;
    logic [7:0] regE;
    logic [7:0] regH;
    logic [7:0] regL;
    logic [7:0] regA;
    logic [7:0] wrEn;
    logic [7:0] wrData;
    logic [7:0] view [8];

    always_comb begin
        wrEn = writeSel;
        wrData = xferData;
        if (hostRegWrite) begin // host preload takes the write port
            wrEn = 8'b1 << hostRegSel;
            wrData = hostData;
        end
    end

    // index M has no register here, the memory takes that write
    always_ff @(posedge clk) begin
        if (rst) begin
            regB <= '0;
            regC <= '0;
            regD <= '0;
            regE <= '0;
            regH <= '0;
            regL <= '0;
            regA <= '0;
        end else begin
            if (wrEn[REG_B]) regB <= wrData;
            if (wrEn[REG_C]) regC <= wrData;
            if (wrEn[REG_D]) regD <= wrData;
            if (wrEn[REG_E]) regE <= wrData;
            if (wrEn[REG_H]) regH <= wrData;
            if (wrEn[REG_L]) regL <= wrData;
            if (wrEn[REG_A]) regA <= wrData;
        end
    end

    always_comb begin
        view[REG_B] = regB;
        view[REG_C] = regC;
        view[REG_D] = regD;
        view[REG_E] = regE;
        view[REG_H] = regH;
        view[REG_L] = regL;
        view[REG_M] = memData; // M reads through to the byte at HL
        view[REG_A] = regA;
        xferData = '0;
        for (int i = 0; i < 8; i++) begin
            if (readSel[i]) begin
                xferData = xferData | view[i];
            end
        end
        hostReadData = view[hostRegSel];
        hl.bytes.h = regH;
        hl.bytes.l = regL;
    end

endmodule

`default_nettype wire

//--- rtl/moveSequencer.sv
/* Move sequencer */
`timescale 1ns/100ps
`default_nettype none

module moveSequencer (
    input wire logic clk,
    input wire logic rst,
    input wire logic opWrite,
    input wire logic [7:0] opByte,
    input wire logic isHalt,
    input wire logic isIllegal,
    output movGroup_pkg::xpt_e xpt,
    output logic decEnable,
    output logic [7:0] opcode,
    output logic opStall,
    output logic busy,
    output logic haltFlag,
    output logic illegalFlag
);
    import movGroup_pkg::*;

    // IDLE -> XREAD -> XWRITE -> XDONE -> IDLE
    always_ff @(posedge clk) begin
        if (rst) begin
            xpt <= XPT_IDLE;
        end else begin
            unique case (xpt)
                XPT_IDLE: begin
                    if (opWrite) begin
                        xpt <= XPT_XREAD;
                    end
                end
                XPT_XREAD: xpt <= XPT_XWRITE;
                XPT_XWRITE: xpt <= XPT_XDONE;
                XPT_XDONE: xpt <= XPT_IDLE;
                default: xpt <= XPT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (opWrite) begin
            opcode <= opByte;
        end
    end

    // flags survive until the next opcode is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            haltFlag <= 1'b0;
            illegalFlag <= 1'b0;
        end else if (opWrite) begin
            haltFlag <= 1'b0;
            illegalFlag <= 1'b0;
        end else if (xpt == XPT_XDONE) begin
            haltFlag <= isHalt;
            illegalFlag <= isIllegal;
        end
    end

    assign busy = (xpt != XPT_IDLE);
    assign decEnable = busy; // opcode is only valid while a move runs
    assign opStall = busy; // hold the next opcode until back in IDLE

    // a running move steps through every state without skipping one
    assert property (@(posedge clk) disable iff (rst)
        (xpt != XPT_IDLE) |=> (xpt == xpt_e'($past(xpt) + 2'd1)))
        else $error("moveSequencer: timing state skipped");

    // the host port must hold a new opcode back while a move is running
    assert property (@(posedge clk) disable iff (rst) opWrite |-> !busy)
        else $error("moveSequencer: opcode accepted while busy");

endmodule

`default_nettype wire

//--- rtl/movDecoder.sv
/* Move-group decoder */
`timescale 1ns/100ps
`default_nettype none

module movDecoder (
    input wire logic enable,
    input wire movGroup_pkg::xpt_e xpt,
    input wire logic [7:0] opcode,
    output logic [7:0] readSel,
    output logic [7:0] writeSel,
    output logic selectAddrHL,
    output logic memWrite,
    output logic isHalt,
    output logic isIllegal
);
    import movGroup_pkg::*;

    logic [1:0] group;
    logic [2:0] dst;
    logic [2:0] src;
    logic isMove;
    logic srcIsM;
    logic dstIsM;
    logic regToReg;
    logic readPhase;
    logic writePhase;

    assign group = opcode[7:6];
    assign dst = opcode[5:3];
    assign src = opcode[2:0];

    assign isMove = enable && (group == 2'b01);
    assign isIllegal = enable && (group != 2'b01);
    assign isHalt = isMove && (dst == REG_M) && (src == REG_M); // 01110110 moves nothing

    // three branches as in 01xxx110, 01110xxx and the rest, with HALT kept out
    assign srcIsM = isMove && (src == REG_M) && !isHalt;
    assign dstIsM = isMove && (dst == REG_M) && !isHalt;
    assign regToReg = isMove && !srcIsM && !dstIsM && !isHalt;

    assign readPhase = (xpt == XPT_XREAD) || (xpt == XPT_XWRITE);
    assign writePhase = (xpt == XPT_XWRITE);

    always_comb begin
        readSel = '0;
        writeSel = '0;
        memWrite = 1'b0;
        if (srcIsM) begin // LD r,(HL)
            readSel[REG_M] = readPhase;
            writeSel[dst] = writePhase;
        end else if (dstIsM) begin // LD (HL),r
            readSel[src] = readPhase;
            memWrite = writePhase;
        end else if (regToReg) begin
            readSel[src] = readPhase;
            writeSel[dst] = writePhase;
        end
    end

    assign selectAddrHL = srcIsM || dstIsM;

    // sampled as each timing state ends, so every state's strobes get checked
    assert property (@(xpt) $onehot0(readSel) && $onehot0(writeSel))
        else $error("movDecoder: read or write strobes not one-hot");

endmodule

`default_nettype wire

//--- rtl/movGroup_pkg.sv
/* Move-group types */
`default_nettype none

package movGroup_pkg;

    // operand field encoding, 8080 order
    typedef enum logic [2:0] {
        REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_M, REG_A
    } regSel_e;

    typedef enum logic [1:0] {
        XPT_IDLE, XPT_XREAD, XPT_XWRITE, XPT_XDONE
    } xpt_e;

    typedef struct packed {
        logic [7:0] h;
        logic [7:0] l;
    } hlBytes_s;

    // HL as one address word or as its two bytes
    typedef union packed {
        logic [15:0] addr;
        hlBytes_s bytes;
    } hlPair_u;

endpackage

`default_nettype wire

//--- include/movGroup_consts.svh
/* Move-group constants */
`ifndef MOVGROUP_CONSTS_SVH
`define MOVGROUP_CONSTS_SVH

// scratch memory is indexed by the low byte of HL
`define MOV_MEM_AW 8

// APB byte offsets
`define MOV_OFS_OPCODE 8'h00
`define MOV_OFS_STATUS 8'h04
`define MOV_OFS_REG 8'h20 // register n sits 4n bytes above this

// bit positions in the status word
`define MOV_ST_BUSY 0
`define MOV_ST_HALT 1
`define MOV_ST_ILLEGAL 2

`endif
